/* tb.f */
uart_pkg.sv
uart_tick_gen.sv
uart_rx.sv
uart_tx.sv
uart_top.sv
uart_checker.sv
tb_uart.sv

/* tb_uart.sv */
`timescale 1ns/1ps

module tb_uart;

  logic               clk;
  logic               rst_h;
  logic               rxd;
  logic               txd;
  uart_pkg::tx_req_t  tx_req;
  logic               tx_ready;
  uart_pkg::rx_word_t rx_word;

  // clk cycles per bit cell
  int bit_cycles;

  // cases from the data file
  string      case_ops[$];
  logic [7:0] case_data[$];
  int         case_flags[$];

  int pass_cnt;
  int fail_cnt;
  int case_errs;
  int cycle_cnt;
  int cycle_limit;

  int         fd;
  int         c;
  int         gap;
  string      line;
  string      op;
  logic [7:0] data;
  int         flag;

  uart_top i_dut (
    .clk      (clk),
    .rst_h    (rst_h),
    .rxd      (rxd),
    .txd      (txd),
    .tx_req   (tx_req),
    .tx_ready (tx_ready),
    .rx_word  (rx_word)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // run limit from the case count
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout, run stopped after %0d cycles", cycle_cnt);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ******************************
  // serial side tasks
  // ******************************

  // one frame onto rxd, start low then lsb first
  task automatic drive_frame(input logic [7:0] value, input logic stop_level);
    logic [9:0] frame;
    int         i;
    frame = {stop_level, value, 1'b0};
    for (i = 0; i < 10; i++) begin
      rxd = frame[i];
      repeat (bit_cycles) @(negedge clk);
    end
    rxd = 1'b1;
  endtask

  // count valid pulses over a window
  task automatic watch_valid(input int cycles, output int pulses, output logic [7:0] got);
    pulses = 0;
    got    = '0;
    repeat (cycles) begin
      @(negedge clk);
      if (rx_word.valid === 1'b1) begin
        pulses++;
        got = rx_word.data;
      end
    end
  endtask

  // wait for the start edge, then sample each cell middle
  task automatic capture_tx(output logic [9:0] bits, output logic seen);
    int waited;
    int i;
    waited = 0;
    bits   = '1;
    while (txd === 1'b1 && waited < 2 * uart_pkg::tick_div) begin
      @(negedge clk);
      waited++;
    end
    seen = (txd === 1'b0);
    if (seen) begin
      repeat (bit_cycles / 2) @(negedge clk);
      for (i = 0; i < 10; i++) begin
        bits[i] = txd;
        if (i < 9) begin
          repeat (bit_cycles) @(negedge clk);
        end
      end
    end
  endtask

  // compare a captured frame, then the ready rise at the stop end
  task automatic check_frame(input logic [7:0] value, input logic [9:0] bits, input logic seen);
    logic [9:0] exp_bits;
    int         i;
    int         waited;
    exp_bits = {1'b1, value, 1'b0};
    if (!seen) begin
      $display("no start bit on txd after the request");
      case_errs++;
    end else begin
      for (i = 0; i < 10; i++) begin
        if (bits[i] !== exp_bits[i]) begin
          $display("error at %0t: txd bit %0d expected %b got %b",
                   $time, i, exp_bits[i], bits[i]);
          case_errs++;
        end
      end
      // half a cell from the stop middle to the end of the frame
      waited = 0;
      while (tx_ready !== 1'b1 && waited < bit_cycles) begin
        @(negedge clk);
        waited++;
      end
      if (tx_ready !== 1'b1) begin
        $display("tx_ready did not return high after the stop bit");
        case_errs++;
      end else if (waited != bit_cycles / 2) begin
        $display("error at %0t: tx_ready rise delay expected %0d got %0d",
                 $time, bit_cycles / 2, waited);
        case_errs++;
      end
    end
  endtask

  // ******************************
  // case runners
  // ******************************

  task automatic run_rx(input string kind, input logic [7:0] value, input int exp_cnt);
    int         pulses;
    logic [7:0] got;
    fork
      begin
        if (kind == "glitch") begin
          // three ticks low, shorter than half a cell
          rxd = 1'b0;
          repeat (3 * uart_pkg::tick_div) @(negedge clk);
          rxd = 1'b1;
        end else begin
          drive_frame(value, kind != "bad_stop");
        end
      end
      // stop start plus two cells
      watch_valid(11 * bit_cycles, pulses, got);
    join
    if (exp_cnt != 0 && pulses == 0) begin
      $display("no rx_word.valid pulse after the frame");
      case_errs++;
    end else if (pulses != exp_cnt) begin
      $display("error at %0t: rx_word.valid pulses expected %0d got %0d",
               $time, exp_cnt, pulses);
      case_errs++;
    end else if (exp_cnt != 0 && got !== value) begin
      $display("error at %0t: rx_word.data expected %h got %h", $time, value, got);
      case_errs++;
    end
  endtask

  task automatic run_tx(input string kind, input logic [7:0] value, input int exp_cnt);
    logic [9:0] bits;
    logic       seen;
    int         extra;
    tx_req.valid = 1'b1;
    tx_req.data  = value;
    @(negedge clk);
    fork
      capture_tx(bits, seen);
      begin
        if (kind == "busy") begin
          // second byte while busy, must be dropped
          if (tx_ready !== 1'b0) begin
            $display("error at %0t: tx_ready expected 0 got %b", $time, tx_ready);
            case_errs++;
          end
          tx_req.data = ~value;
          @(negedge clk);
        end
        tx_req = '0;
      end
    join
    check_frame(value, bits, seen);
    if (kind == "busy") begin
      extra = 0;
      repeat (2 * 10 * bit_cycles) begin
        @(negedge clk);
        if (txd === 1'b0) begin
          extra = 1;
        end
      end
      if (extra != exp_cnt) begin
        $display("error at %0t: txd second frame expected %0d got %0d", $time, exp_cnt, extra);
        case_errs++;
      end
    end
  endtask

  task automatic finish_case(input string name);
    if (case_errs == 0) begin
      pass_cnt++;
      $display("%s: ok", name);
    end else begin
      fail_cnt++;
      $display("%s: failed with %0d errors", name, case_errs);
    end
  endtask

  // ******************************
  // main sequence
  // ******************************

  initial begin
    clk         = 1'b0;
    rst_h       = 1'b1;
    rxd         = 1'b1;
    tx_req      = '0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    cycle_cnt   = 0;
    cycle_limit = 100;
    bit_cycles  = uart_pkg::oversample * uart_pkg::tick_div;
    void'($urandom(32'h4c3f_6202));

    // op, byte in hex, expected flag
    fd = $fopen("uart_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open uart_cases.txt");
      fail_cnt++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") begin
          if ($sscanf(line, "%s %h %d", op, data, flag) == 3) begin
            case_ops.push_back(op);
            case_data.push_back(data);
            case_flags.push_back(flag);
          end
        end
      end
      $fclose(fd);
    end
    cycle_limit = case_ops.size() * 1000 + 100;

    repeat (2) @(negedge clk);
    rst_h = 1'b0;

    // idle state out of reset
    case_errs = 0;
    if (txd !== 1'b1) begin
      $display("error at %0t: txd expected 1 got %b", $time, txd);
      case_errs++;
    end
    if (tx_ready !== 1'b1) begin
      $display("error at %0t: tx_ready expected 1 got %b", $time, tx_ready);
      case_errs++;
    end
    if (rx_word !== '0) begin
      $display("error at %0t: rx_word expected %h got %h", $time, 9'h000, rx_word);
      case_errs++;
    end
    finish_case("reset");

    for (c = 0; c < case_ops.size(); c++) begin
      case_errs = 0;
      gap       = $urandom % 21;
      repeat (gap) @(negedge clk);
      case (case_ops[c])
        "send", "busy": run_tx(case_ops[c], case_data[c], case_flags[c]);
        "receive", "glitch", "bad_stop": run_rx(case_ops[c], case_data[c], case_flags[c]);
        default: begin
          $display("unknown operation %s in case %0d", case_ops[c], c);
          case_errs++;
        end
      endcase
      finish_case($sformatf("case %0d %s %h", c, case_ops[c], case_data[c]));
    end

    $display("tests passed %0d, failed %0d, assertion failures %0d",
             pass_cnt, fail_cnt, i_dut.i_checker.assert_fails);
    if (fail_cnt == 0 && i_dut.i_checker.assert_fails == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* uart_cases.txt */
# op: send, receive, glitch, bad_stop or busy; byte: hex; exp: 1 = result expected, 0 = none
# busy sends byte then its complement while busy, exp counts the second frame
send     a5  1
send     00  1
send     ff  1
receive  3c  1
receive  81  1
receive  00  1
glitch   00  0
receive  5a  1
bad_stop c3  0
receive  7e  1
busy     96  0
receive  ff  1
send     01  1

/* uart_checker.sv */
`timescale 1ns/1ps

module uart_checker (
  input logic clk,
  input logic rst_h,
  input logic tick,
  input logic txd,
  input logic tx_ready,
  input logic rx_valid
);

  // count of failed assertions
  int unsigned assert_fails = 0;

  // ******************************
  // line and pulse rules
  // ******************************

  // line idles high while ready
  a_idle_line: assert property (@(posedge clk) disable iff (rst_h) tx_ready |-> txd)
    else begin
      assert_fails++;
      $error("txd low while tx_ready high");
    end

  // valid is a single-cycle pulse
  a_valid_pulse: assert property (@(posedge clk) disable iff (rst_h) rx_valid |=> !rx_valid)
    else begin
      assert_fails++;
      $error("rx_word.valid high for two cycles");
    end

  // tick is a one-cycle enable
  a_tick_pulse: assert property (@(posedge clk) disable iff (rst_h) tick |=> !tick)
    else begin
      assert_fails++;
      $error("tick high for two cycles");
    end

endmodule

bind uart_top uart_checker i_checker (
  .clk      (clk),
  .rst_h    (rst_h),
  .tick     (tick),
  .txd      (txd),
  .tx_ready (tx_ready),
  .rx_valid (rx_word.valid)
);

/* uart_pkg.sv */
package uart_pkg;

  // ******************************
  // frame format
  // ******************************

  // data bits per frame, sent lsb first
  localparam int word_len = 8;

  // oversample ticks in one bit cell
  localparam int oversample = 16;

  // ticks from the start edge to the middle of the start bit
  localparam int half_cell = oversample / 2;

  // ******************************
  // oversample divider
  // ******************************

  // clk cycles per oversample tick
  // small value so a frame is short in simulation
  localparam int unsigned tick_div = 4;

  // divider counter width follows the divider range
  localparam int tick_cnt_w = $clog2(tick_div);

  typedef logic [tick_cnt_w-1:0] tick_cnt_t;

  // ******************************
  // shared counters and words
  // ******************************

  // ticks inside one bit cell
  typedef logic [$clog2(oversample)-1:0] cell_cnt_t;

  // data bits done, must reach word_len
  typedef logic [$clog2(word_len+1)-1:0] bit_cnt_t;

  // host transmit request
  // accepted while tx_ready is high
  typedef struct packed {
    logic                valid;
    logic [word_len-1:0] data;
  } tx_req_t;

  // received byte
  // valid is a one-cycle pulse, data holds until the next good frame
  typedef struct packed {
    logic                valid;
    logic [word_len-1:0] data;
  } rx_word_t;

endpackage

/* uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
  input  logic               clk,
  input  logic               rst_h,
  input  logic               tick,
  input  logic               rxd,
  output uart_pkg::rx_word_t rx_word
);

  // receiver states
  typedef enum logic [2:0] {
    st_idle,
    st_center,
    st_wait,
    st_sample,
    st_stop
  } rx_state_t;

  rx_state_t                     state;

  // two-flop synchroniser
  logic                          rxd_meta;
  logic                          rxd_s;

  // line seen high on an idle tick
  logic                          armed;

  uart_pkg::cell_cnt_t           cell_cnt;
  uart_pkg::bit_cnt_t            bit_cnt;
  logic [uart_pkg::word_len-1:0] shift_reg;

  // tick strobes at the half cell and full cell points
  logic                          half_done;
  logic                          cell_done;

  // good stop bit seen this cycle
  logic                          stop_ok;

  // ******************************
  // input synchroniser
  // ******************************

  // idle level is high
  always_ff @(posedge clk or posedge rst_h) begin
    if (rst_h) begin
      rxd_meta <= 1'b1;
      rxd_s    <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_s    <= rxd_meta;
    end
  end

  // ******************************
  // bit cell timing
  // ******************************

  assign half_done = tick &&
                     (cell_cnt == uart_pkg::cell_cnt_t'(uart_pkg::half_cell - 1));
  assign cell_done = tick &&
                     (cell_cnt == uart_pkg::cell_cnt_t'(uart_pkg::oversample - 1));

  // ******************************
  // state machine
  // ******************************

  always_ff @(posedge clk or posedge rst_h) begin
    if (rst_h) begin
      state    <= st_idle;
      armed    <= 1'b0;
      cell_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      case (state)
        // look for a high to low edge on the tick
        st_idle: begin
          if (tick) begin
            armed <= rxd_s;
            if (armed && !rxd_s) begin
              state    <= st_center;
              cell_cnt <= '0;
            end
          end
        end

        // half a cell to the middle of the start bit
        st_center: begin
          if (half_done) begin
            cell_cnt <= '0;
            bit_cnt  <= '0;
            // still low means a real start bit
            if (rxd_s) begin
              state <= st_idle;
            end else begin
              state <= st_wait;
            end
          end else if (tick) begin
            cell_cnt <= cell_cnt + 1'b1;
          end
        end

        // one full cell to the next sample point
        st_wait: begin
          if (cell_done) begin
            cell_cnt <= '0;
            // next point is the stop bit once all data bits are in
            if (bit_cnt == uart_pkg::bit_cnt_t'(uart_pkg::word_len)) begin
              state <= st_stop;
            end else begin
              state <= st_sample;
            end
          end else if (tick) begin
            cell_cnt <= cell_cnt + 1'b1;
          end
        end

        // single cycle where the shift register takes the bit
        st_sample: begin
          bit_cnt <= bit_cnt + 1'b1;
          state   <= st_wait;
        end

        // stop bit checked in stop_ok
        // armed is low so a held-low line does not restart
        st_stop: begin
          state <= st_idle;
        end

        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ******************************
  // data path
  // ******************************

  // lsb arrives first and enters at the top
  always_ff @(posedge clk) begin
    if (state == st_sample) begin
      shift_reg <= {rxd_s, shift_reg[uart_pkg::word_len-1:1]};
    end
  end

  // frames with a low stop bit are dropped
  assign stop_ok = (state == st_stop) && rxd_s;

  // registered outputs
  // valid one cycle after the stop sample
  always_ff @(posedge clk or posedge rst_h) begin
    if (rst_h) begin
      rx_word <= '0;
    end else begin
      rx_word.valid <= stop_ok;
      if (stop_ok) begin
        rx_word.data <= shift_reg;
      end
    end
  end

endmodule

/* uart_tick_gen.sv */
`timescale 1ns/1ps

module uart_tick_gen (
  input  logic clk,
  input  logic rst_h,
  output logic tick
);

  // free-running divider count
  uart_pkg::tick_cnt_t div_cnt;

  // last count of the divider period
  logic wrap;

  // ******************************
  // divider
  // ******************************

  // wrap at tick_div - 1
  assign wrap = (div_cnt == uart_pkg::tick_cnt_t'(uart_pkg::tick_div - 1));

  always_ff @(posedge clk or posedge rst_h) begin
    if (rst_h) begin
      div_cnt <= '0;
    end else if (wrap) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // one-cycle enable in the wrap cycle
  // counter comes from a flop so no glitch
  assign tick = wrap;

endmodule

/* uart_top.sv */
`timescale 1ns/1ps

module uart_top (
  input  logic               clk,
  input  logic               rst_h,
  input  logic               rxd,
  output logic               txd,
  input  uart_pkg::tx_req_t  tx_req,
  output logic               tx_ready,
  output uart_pkg::rx_word_t rx_word
);

  // shared 16x oversample enable
  logic tick;

  // ******************************
  // oversample tick
  // ******************************

  uart_tick_gen i_tick_gen (
    .clk   (clk),
    .rst_h (rst_h),
    .tick  (tick)
  );

  // ******************************
  // receive side
  // ******************************

  uart_rx i_rx (
    .clk     (clk),
    .rst_h   (rst_h),
    .tick    (tick),
    .rxd     (rxd),
    .rx_word (rx_word)
  );

  // ******************************
  // transmit side
  // ******************************

  // request/ready handshake, no queue
  uart_tx i_tx (
    .clk      (clk),
    .rst_h    (rst_h),
    .tick     (tick),
    .tx_req   (tx_req),
    .tx_ready (tx_ready),
    .txd      (txd)
  );

endmodule

/* uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
  input  logic              clk,
  input  logic              rst_h,
  input  logic              tick,
  input  uart_pkg::tx_req_t tx_req,
  output logic              tx_ready,
  output logic              txd
);

  // transmitter states
  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } tx_state_t;

  tx_state_t                     state;

  // byte loaded, waiting for the next tick to start
  logic                          start_pend;

  uart_pkg::cell_cnt_t           cell_cnt;
  uart_pkg::bit_cnt_t            bit_cnt;
  logic [uart_pkg::word_len-1:0] shift_reg;

  logic                          accept;
  logic                          cell_done;
  logic                          last_bit;

  // ******************************
  // handshake and timing strobes
  // ******************************

  // requests while busy are dropped
  assign accept    = tx_req.valid && tx_ready;

  // sixteenth tick of the current cell
  assign cell_done = tick &&
                     (cell_cnt == uart_pkg::cell_cnt_t'(uart_pkg::oversample - 1));

  // data bit now on the line is the msb
  assign last_bit  = (bit_cnt == uart_pkg::bit_cnt_t'(uart_pkg::word_len - 1));

  // ******************************
  // shift register
  // ******************************

  // lsb goes out first
  always_ff @(posedge clk) begin
    if (accept) begin
      shift_reg <= tx_req.data;
    end else if ((state == st_data) && cell_done) begin
      shift_reg <= {1'b1, shift_reg[uart_pkg::word_len-1:1]};
    end
  end

  // line select from state
  always_comb begin
    case (state)
      st_start: txd = 1'b0;
      st_data:  txd = shift_reg[0];
      default:  txd = 1'b1;
    endcase
  end

  // ******************************
  // state machine
  // ******************************

  always_ff @(posedge clk or posedge rst_h) begin
    if (rst_h) begin
      state      <= st_idle;
      start_pend <= 1'b0;
      tx_ready   <= 1'b1;
      cell_cnt   <= '0;
      bit_cnt    <= '0;
    end else begin
      // cell counter runs on the tick outside idle
      if ((state != st_idle) && tick) begin
        if (cell_done) begin
          cell_cnt <= '0;
        end else begin
          cell_cnt <= cell_cnt + 1'b1;
        end
      end

      case (state)
        // load on accept, start line on the next tick
        st_idle: begin
          if (accept) begin
            start_pend <= 1'b1;
            tx_ready   <= 1'b0;
          end else if (start_pend && tick) begin
            start_pend <= 1'b0;
            cell_cnt   <= '0;
            state      <= st_start;
          end
        end

        // start bit for one cell
        st_start: begin
          if (cell_done) begin
            bit_cnt <= '0;
            state   <= st_data;
          end
        end

        // one cell per data bit
        st_data: begin
          if (cell_done) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (last_bit) begin
              state <= st_stop;
            end
          end
        end

        // stop bit for one cell, ready again at its end
        st_stop: begin
          if (cell_done) begin
            tx_ready <= 1'b1;
            state    <= st_idle;
          end
        end

        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule
